// ==== adder_tree.sv ====
`timescale 1ns/1ps
`include "dp_params.svh"

module adder_tree
  import dp_data_pkg::*;
#(
  parameter int VECTOR_SIZE = `DP_VECTOR_SIZE
) (
  input  logic      clk,
  input  logic      reset,
  // product vector from the multiplier
  input  prod_vec_t ind,
  input  beat_tag_t in_tag,
  input  logic      in_valid,
  output logic      in_ready,
  // reduced sum
  output sum_t      outd,
  output beat_tag_t out_tag,
  output logic      out_valid,
  input  logic      out_ready
);

  localparam int LEVELS = $clog2(VECTOR_SIZE);

  for (genvar l = 0; l < LEVELS; l++) begin : g_level
    // operand width into this level and result width out of it
    localparam int IN_W  = `DP_PROD_WIDTH + l;
    localparam int OUT_W = IN_W + 1;
    localparam int OUT_N = VECTOR_SIZE >> (l + 1);

    logic signed [IN_W-1:0]  in_data [2*OUT_N];
    logic signed [OUT_W-1:0] sum_q   [OUT_N];
    logic                    up_valid;
    beat_tag_t               up_tag;
    logic                    stage_ready;
    logic                    down_ready;
    logic                    valid_q;
    beat_tag_t               tag_q;
    logic                    take;

    // upstream side is the tree input or the level before
    if (l == 0) begin : g_from_input
      assign up_valid = in_valid;
      assign up_tag   = in_tag;
      for (genvar i = 0; i < 2 * OUT_N; i++) begin : g_in
        assign in_data[i] = ind[i];
      end
    end else begin : g_from_level
      assign up_valid = g_level[l-1].valid_q;
      assign up_tag   = g_level[l-1].tag_q;
      for (genvar i = 0; i < 2 * OUT_N; i++) begin : g_in
        assign in_data[i] = g_level[l-1].sum_q[i];
      end
    end

    // downstream side is the tree output or the next level
    if (l == LEVELS - 1) begin : g_to_output
      assign down_ready = out_ready;
    end else begin : g_to_level
      assign down_ready = g_level[l+1].stage_ready;
    end

    // takes a new item when empty or handing its item on
    assign stage_ready = !valid_q || down_ready;
    assign take        = up_valid && stage_ready;

    always_ff @(posedge clk) begin
      if (reset) begin
        valid_q <= 1'b0;
      end else if (stage_ready) begin
        valid_q <= up_valid;
      end
    end

    // pair sums with one bit of sign extension
    always_ff @(posedge clk) begin
      if (take) begin
        tag_q <= up_tag;
        for (int i = 0; i < OUT_N; i++) begin
          sum_q[i] <= {in_data[2*i][IN_W-1], in_data[2*i]}
                    + {in_data[2*i+1][IN_W-1], in_data[2*i+1]};
        end
      end
    end

    // a full stage is never overwritten while stalled
    a_level_hold: assert property (
      @(posedge clk) disable iff (reset)
      valid_q && !down_ready |=> valid_q && $stable(tag_q) && $stable(sum_q[0])
    );
  end

  assign in_ready  = g_level[0].stage_ready;
  assign outd      = g_level[LEVELS-1].sum_q[0];
  assign out_tag   = g_level[LEVELS-1].tag_q;
  assign out_valid = g_level[LEVELS-1].valid_q;

endmodule

// ==== build.f ====
+incdir+.
dp_ctrl_pkg.sv
dp_data_pkg.sv
vector_mult.sv
adder_tree.sv
dot_product.sv
dot_accumulator.sv
dot_product_top.sv
tb_dot_product_top.sv

// ==== dot_accumulator.sv ====
`timescale 1ns/1ps
`include "dp_params.svh"

module dot_accumulator
  import dp_ctrl_pkg::*, dp_data_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  // block dot products with their tags
  input  sum_t      ind,
  input  beat_tag_t in_tag,
  input  logic      in_valid,
  output logic      in_ready,
  // results
  output acc_t      result,
  output logic      result_valid,
  input  logic      result_ready
);

  localparam int EXT_W = `DP_ACC_WIDTH - `DP_SUM_WIDTH;

  acc_state_e state_q;
  acc_t       run_sum_q;
  acc_t       in_ext;
  acc_t       chain_total;
  logic       in_fire;
  logic       emit;

  // one result register so accept when it is empty or draining
  assign in_ready = !result_valid || result_ready;
  assign in_fire  = in_valid && in_ready;

  // block sum widened to the result width
  assign in_ext = {{EXT_W{ind[`DP_SUM_WIDTH-1]}}, ind};

  // a new chain starts from zero
  assign chain_total = (state_q == ACC_CHAIN) ? run_sum_q + in_ext : in_ext;

  // pass beats and chain ends produce a result
  assign emit = (in_tag.op != OP_CHAIN) || in_tag.last;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q      <= ACC_IDLE;
      result_valid <= 1'b0;
    end else begin
      if (result_ready) begin
        result_valid <= 1'b0;
      end
      if (in_fire) begin
        if (emit) begin
          result_valid <= 1'b1;
          state_q      <= ACC_IDLE;
        end else begin
          state_q <= ACC_CHAIN;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      case (in_tag.op)
        OP_CHAIN: begin
          run_sum_q <= chain_total;
          if (in_tag.last) begin
            result <= chain_total;
          end
        end
        default: begin
          result <= in_ext;
        end
      endcase
    end
  end

  // only pass and chain are legal ops
  a_no_reserved_op: assert property (
    @(posedge clk) disable iff (reset)
    in_valid |-> in_tag.op inside {OP_PASS, OP_CHAIN}
  );

  // an open chain is never interleaved with a pass beat
  a_no_pass_in_chain: assert property (
    @(posedge clk) disable iff (reset)
    in_valid && in_tag.op == OP_PASS |-> state_q == ACC_IDLE
  );

endmodule

// ==== dot_product.sv ====
`timescale 1ns/1ps
`include "dp_params.svh"

module dot_product
  import dp_data_pkg::*;
#(
  // elements per block
  parameter int VECTOR_SIZE = `DP_VECTOR_SIZE
) (
  input  logic      clk,
  input  logic      reset,
  // activations with the beat tag
  input  act_vec_t  act,
  input  beat_tag_t act_tag,
  input  logic      act_valid,
  output logic      act_ready,
  // weights
  input  w_vec_t    weights,
  input  logic      w_valid,
  output logic      w_ready,
  // one dot product per block
  output sum_t      outd,
  output beat_tag_t out_tag,
  output logic      out_valid,
  input  logic      out_ready
);

  // products between multiply and reduce
  prod_vec_t pv;
  beat_tag_t pv_tag;
  logic      pv_valid;
  logic      pv_ready;

  // reduced stream
  sum_t      sum;
  beat_tag_t sum_tag;
  logic      sum_valid;
  logic      sum_ready;

  vector_mult #(
    .VECTOR_SIZE(VECTOR_SIZE)
  ) vector_mult_inst (
    .clk      (clk),
    .reset    (reset),
    .act      (act),
    .act_tag  (act_tag),
    .act_valid(act_valid),
    .act_ready(act_ready),
    .weights  (weights),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .outd     (pv),
    .out_tag  (pv_tag),
    .out_valid(pv_valid),
    .out_ready(pv_ready)
  );

  // sum = sum(pv)
  adder_tree #(
    .VECTOR_SIZE(VECTOR_SIZE)
  ) adder_tree_inst (
    .clk      (clk),
    .reset    (reset),
    .ind      (pv),
    .in_tag   (pv_tag),
    .in_valid (pv_valid),
    .in_ready (pv_ready),
    .outd     (sum),
    .out_tag  (sum_tag),
    .out_valid(sum_valid),
    .out_ready(sum_ready)
  );

  // integer only so the tree output is the block result
  assign outd      = sum;
  assign out_tag   = sum_tag;
  assign out_valid = sum_valid;
  assign sum_ready = out_ready;

endmodule

// ==== dot_product_top.sv ====
`timescale 1ns/1ps
`include "dp_params.svh"

module dot_product_top
  import dp_data_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  // activation beats carry the tag
  input  act_beat_t act,
  input  logic      act_valid,
  output logic      act_ready,
  // weight vectors
  input  w_vec_t    weights,
  input  logic      w_valid,
  output logic      w_ready,
  // final results
  output acc_t      result,
  output logic      result_valid,
  input  logic      result_ready
);

  // block dot products into the accumulator
  sum_t      dp_sum;
  beat_tag_t dp_tag;
  logic      dp_valid;
  logic      dp_ready;

  // beat split into vector and tag at the port
  dot_product #(
    .VECTOR_SIZE(`DP_VECTOR_SIZE)
  ) dot_product_inst (
    .clk      (clk),
    .reset    (reset),
    .act      (act.vec),
    .act_tag  (act.tag),
    .act_valid(act_valid),
    .act_ready(act_ready),
    .weights  (weights),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .outd     (dp_sum),
    .out_tag  (dp_tag),
    .out_valid(dp_valid),
    .out_ready(dp_ready)
  );

  dot_accumulator dot_accumulator_inst (
    .clk         (clk),
    .reset       (reset),
    .ind         (dp_sum),
    .in_tag      (dp_tag),
    .in_valid    (dp_valid),
    .in_ready    (dp_ready),
    .result      (result),
    .result_valid(result_valid),
    .result_ready(result_ready)
  );

endmodule

// ==== dp_ctrl_pkg.sv ====
package dp_ctrl_pkg;

  // what the accumulator does with one dot product
  // 2'b10 and 2'b11 are reserved
  typedef enum logic [1:0] {
    // emit this dot product on its own
    OP_PASS  = 2'b00,
    // add into the running sum
    OP_CHAIN = 2'b01
  } acc_op_e;

  // accumulator state
  typedef enum logic {
    // no chain open
    ACC_IDLE  = 1'b0,
    // running sum holds a partial chain
    ACC_CHAIN = 1'b1
  } acc_state_e;

endpackage

// ==== dp_data_pkg.sv ====
`include "dp_params.svh"

package dp_data_pkg;
  import dp_ctrl_pkg::*;

  // single elements, all signed
  typedef logic signed [`DP_ACT_WIDTH-1:0] act_t;
  typedef logic signed [`DP_W_WIDTH-1:0] w_t;
  typedef logic signed [`DP_PROD_WIDTH-1:0] prod_t;

  // element vectors with element 0 in the low bits
  typedef act_t [`DP_VECTOR_SIZE-1:0] act_vec_t;
  typedef w_t [`DP_VECTOR_SIZE-1:0] w_vec_t;
  typedef prod_t [`DP_VECTOR_SIZE-1:0] prod_vec_t;

  // reduced block sum out of the tree
  typedef logic signed [`DP_SUM_WIDTH-1:0] sum_t;

  // accumulator result
  typedef logic signed [`DP_ACC_WIDTH-1:0] acc_t;

  // tag that follows every item down the pipeline
  typedef struct packed {
    acc_op_e op;
    // closes a chain
    logic    last;
  } beat_tag_t;

  // activation beat as seen on the top level
  typedef struct packed {
    act_vec_t  vec;
    beat_tag_t tag;
  } act_beat_t;

endpackage

// ==== dp_params.svh ====
`ifndef DP_PARAMS_SVH
`define DP_PARAMS_SVH

// element width of the activation stream
`define DP_ACT_WIDTH 16

// element width of the weight stream
`define DP_W_WIDTH 8

// elements per block
`define DP_VECTOR_SIZE 4

// full precision product of one element pair
`define DP_PROD_WIDTH (`DP_ACT_WIDTH + `DP_W_WIDTH)

// the tree grows one bit per level
`define DP_SUM_WIDTH (`DP_PROD_WIDTH + $clog2(`DP_VECTOR_SIZE))

// room for long chains of blocks
`define DP_ACC_WIDTH 40

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the dot product testbench with Verilator and runs it once
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_dot_product_top \
  -f build.f

# the simulator exits non-zero on a failed check, the log decides the verdict
./obj_dir/Vtb_dot_product_top 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
  echo "run_sim: FAIL"
  exit 1
fi

if ! grep -q "Simulation completed successfully" sim.log; then
  echo "run_sim: FAIL, simulation ended without a verdict"
  exit 1
fi

echo "run_sim: PASS"

// ==== tb_dot_product_top.sv ====
`timescale 1ns/1ps
`include "dp_params.svh"

module tb_dot_product_top
  import dp_ctrl_pkg::*, dp_data_pkg::*;
;

  // beats in the random phase and in the full rate phase
  localparam int N_RAND = 60;
  localparam int N_STEADY = 12;
  localparam int N_BEATS = N_RAND + N_STEADY;
  // rising edges from input transfer to result transfer at full rate
  localparam int LATENCY = 4;
  localparam int BEAT_TIMEOUT = 100;
  localparam int DRAIN_TIMEOUT = 500;

  // one expected result with the edge of its input transfer
  typedef struct packed {
    acc_t        value;
    logic [31:0] cycle;
    logic        timed;
  } exp_entry_t;

  logic      clk;
  logic      reset;
  act_beat_t act;
  logic      act_valid;
  logic      act_ready;
  w_vec_t    weights;
  logic      w_valid;
  logic      w_ready;
  acc_t      result;
  logic      result_valid;
  logic      result_ready;

  // prepared stimulus
  act_beat_t act_beats [N_BEATS];
  w_vec_t    w_beats   [N_BEATS];

  // reference model state
  exp_entry_t  exp_q [$];
  longint      chain_sum = 0;
  logic        act_took = 1'b0;
  logic [31:0] cycle = '0;
  logic        seen_input = 1'b0;
  int          n_results = 0;
  int          n_expected = 0;
  logic        head_valid = 1'b0;
  acc_t        head_value = '0;
  logic [31:0] head_cycle = '0;
  logic        head_timed = 1'b0;
  // phase flags
  logic        steady = 1'b0;
  logic        run_done = 1'b0;

  dot_product_top i_dut (
    .clk         (clk),
    .reset       (reset),
    .act         (act),
    .act_valid   (act_valid),
    .act_ready   (act_ready),
    .weights     (weights),
    .w_valid     (w_valid),
    .w_ready     (w_ready),
    .result      (result),
    .result_valid(result_valid),
    .result_ready(result_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  // signed dot product of one block in a width that never wraps
  function automatic longint dot_of(input act_vec_t a, input w_vec_t w);
    longint s;
    s = 0;
    for (int i = 0; i < `DP_VECTOR_SIZE; i++) begin
      s += longint'(a[i]) * longint'(w[i]);
    end
    return s;
  endfunction

  task automatic fill_random(input int i, input acc_op_e op, input logic last);
    for (int e = 0; e < `DP_VECTOR_SIZE; e++) begin
      act_beats[i].vec[e] = act_t'($urandom());
      w_beats[i][e]       = w_t'($urandom());
    end
    act_beats[i].tag.op   = op;
    act_beats[i].tag.last = last;
  endtask

  task automatic build_beats();
    int idx;
    int run;
    // corner products first
    // min times min is the largest positive product
    for (int i = 0; i < 4; i++) begin
      for (int e = 0; e < `DP_VECTOR_SIZE; e++) begin
        act_beats[i].vec[e] = (i % 2 == 0) ? act_t'(16'h8000) : act_t'(16'h7fff);
        w_beats[i][e]       = (i < 2) ? w_t'(8'h80) : w_t'(8'h7f);
      end
      act_beats[i].tag = '{op: OP_PASS, last: 1'b0};
    end
    idx = 4;
    while (idx < N_RAND) begin
      run = ($urandom_range(0, 2) == 0) ? int'($urandom_range(2, 5)) : 0;
      if (run == 0) begin
        fill_random(idx, OP_PASS, 1'b0);
        idx++;
      end else begin
        // a chain never runs past the random phase
        if (run > N_RAND - idx) begin
          run = N_RAND - idx;
        end
        for (int k = 0; k < run; k++) begin
          fill_random(idx + k, OP_CHAIN, k == run - 1);
        end
        idx += run;
      end
    end
    for (int i = N_RAND; i < N_BEATS; i++) begin
      fill_random(i, OP_PASS, 1'b0);
    end
  endtask

  // presents beats on both streams with valids rising independently unless held
  task automatic drive_beats(input int first, input int count, input bit hold_valid);
    int idx;
    int waited;
    idx = first;
    waited = 0;
    while (idx < first + count && waited < BEAT_TIMEOUT) begin
      @(negedge clk);
      waited++;
      if (act_took) begin
        idx++;
        waited = 0;
        act_valid = 1'b0;
        w_valid = 1'b0;
      end
      if (idx < first + count) begin
        if (!act_valid && (hold_valid || $urandom_range(0, 1) == 1)) begin
          act = act_beats[idx];
          act_valid = 1'b1;
        end
        if (!w_valid && (hold_valid || $urandom_range(0, 1) == 1)) begin
          weights = w_beats[idx];
          w_valid = 1'b1;
        end
      end
      result_ready = hold_valid ? 1'b1 : ($urandom_range(0, 3) != 0);
    end
    if (idx < first + count) begin
      fail_run("Timeout: input beats were not accepted by the DUT");
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      fail_run("Timeout: expected results never came out of the DUT");
    end
  endtask

  // reference model fed by the transfers seen on each rising edge
  always @(posedge clk) begin
    exp_entry_t entry;
    longint     dot;
    cycle <= cycle + 1;
    if (reset) begin
      act_took = 1'b0;
      chain_sum = 0;
      exp_q.delete();
      seen_input <= 1'b0;
      n_results <= 0;
      n_expected <= 0;
      head_valid <= 1'b0;
    end else begin
      act_took = act_valid && act_ready;
      if (result_valid && result_ready) begin
        n_results <= n_results + 1;
        if (exp_q.size() != 0) begin
          void'(exp_q.pop_front());
        end
      end
      if (act_took) begin
        seen_input <= 1'b1;
        dot = dot_of(act.vec, weights);
        if (act.tag.op == OP_CHAIN) begin
          chain_sum += dot;
        end
        // pass beats and chain ends each owe one result
        if (act.tag.op == OP_PASS || act.tag.last) begin
          entry.value = (act.tag.op == OP_PASS) ? acc_t'(dot) : acc_t'(chain_sum);
          entry.cycle = cycle;
          entry.timed = steady;
          exp_q.push_back(entry);
          n_expected <= n_expected + 1;
          chain_sum = 0;
        end
      end
      head_valid <= exp_q.size() != 0;
      if (exp_q.size() != 0) begin
        head_value <= exp_q[0].value;
        head_cycle <= exp_q[0].cycle;
        head_timed <= exp_q[0].timed;
      end
    end
  end

  // nothing comes out before anything went in
  a_quiet_until_input: assert property (
    @(posedge clk) disable iff (reset) !seen_input |-> !result_valid
  ) else fail_run($sformatf("Error: result_valid = 0x%h before any input transfer",
                            $sampled(result_valid)));

  a_result_value: assert property (
    @(posedge clk) disable iff (reset)
    result_valid && result_ready && head_valid |-> result == head_value
  ) else fail_run($sformatf("Error: result = 0x%h, expected 0x%h",
                            $sampled(result), $sampled(head_value)));

  a_no_extra_result: assert property (
    @(posedge clk) disable iff (reset) result_valid && result_ready |-> head_valid
  ) else fail_run("A result was transferred with no expected value left");

  a_result_hold: assert property (
    @(posedge clk) disable iff (reset)
    result_valid && !result_ready |=> result_valid && $stable(result)
  ) else fail_run($sformatf("Error: result_valid = 0x%h, result = 0x%h after a stall",
                            $sampled(result_valid), $sampled(result)));

  a_ready_match: assert property (
    @(posedge clk) disable iff (reset) act_ready == w_ready
  ) else fail_run($sformatf("Error: act_ready = 0x%h, w_ready = 0x%h",
                            $sampled(act_ready), $sampled(w_ready)));

  // the join never takes one stream alone
  a_join_only: assert property (
    @(posedge clk) disable iff (reset) act_ready |-> act_valid && w_valid
  ) else fail_run($sformatf("Error: act_ready = 0x%h, act_valid = 0x%h, w_valid = 0x%h",
                            $sampled(act_ready), $sampled(act_valid), $sampled(w_valid)));

  a_full_rate: assert property (
    @(posedge clk) disable iff (reset) steady && act_valid && w_valid |-> act_ready
  ) else fail_run($sformatf("Error: act_ready = 0x%h at full rate",
                            $sampled(act_ready)));

  // result taken LATENCY edges after its input transfer
  a_latency: assert property (
    @(posedge clk) disable iff (reset)
    result_valid && result_ready && head_valid && head_timed
    |-> cycle - head_cycle == LATENCY
  ) else fail_run($sformatf("Error: result latency = 0x%h, expected 0x%h",
                            $sampled(cycle) - $sampled(head_cycle), LATENCY));

  a_count_match: assert property (
    @(posedge clk) disable iff (reset) run_done |-> n_results == n_expected && !head_valid
  ) else fail_run($sformatf("Error: n_results = 0x%h, n_expected = 0x%h",
                            $sampled(n_results), $sampled(n_expected)));

  initial begin
    void'($urandom(32'h1bfc_6cdc));
    reset = 1'b1;
    act = '0;
    act_valid = 1'b0;
    weights = '0;
    w_valid = 1'b0;
    result_ready = 1'b0;
    build_beats();
    repeat (5) @(negedge clk);
    reset = 1'b0;
    // random valids and back-pressure
    drive_beats(0, N_RAND, 1'b0);
    result_ready = 1'b1;
    wait_drain();
    // back to back beats with result_ready held high
    steady = 1'b1;
    drive_beats(N_RAND, N_STEADY, 1'b1);
    wait_drain();
    steady = 1'b0;
    run_done = 1'b1;
    repeat (2) @(negedge clk);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== vector_mult.sv ====
`timescale 1ns/1ps
`include "dp_params.svh"

module vector_mult
  import dp_data_pkg::*;
#(
  parameter int VECTOR_SIZE = `DP_VECTOR_SIZE
) (
  input  logic      clk,
  input  logic      reset,
  // activation vector and its tag
  input  act_vec_t  act,
  input  beat_tag_t act_tag,
  input  logic      act_valid,
  output logic      act_ready,
  // weight vector
  input  w_vec_t    weights,
  input  logic      w_valid,
  output logic      w_ready,
  // registered products
  output prod_vec_t outd,
  output beat_tag_t out_tag,
  output logic      out_valid,
  input  logic      out_ready
);

  prod_vec_t prod;
  logic      slot_free;
  logic      join_fire;

  // output register empty or drained this cycle
  assign slot_free = !out_valid || out_ready;

  // both streams move together or not at all
  assign join_fire = act_valid && w_valid && slot_free;
  assign act_ready = join_fire;
  assign w_ready   = join_fire;

  // pairwise signed multiply at full precision
  always_comb begin
    prod = '0;
    for (int i = 0; i < VECTOR_SIZE; i++) begin
      prod[i] = act[i] * weights[i];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (slot_free) begin
      out_valid <= join_fire;
    end
  end

  // products and tag only load on a join transfer
  always_ff @(posedge clk) begin
    if (join_fire) begin
      outd    <= prod;
      out_tag <= act_tag;
    end
  end

  // a stalled item stays put until it is taken
  a_out_stable: assert property (
    @(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(outd) && $stable(out_tag)
  );

endmodule
